//--- hw/address_gen.sv
`timescale 1ns/1ns

module address_gen (
    input  logic                 clk,
    input  logic                 reset_n,
    input  vlsu_pkg::lsu_state_e state_i,
    input  vlsu_pkg::addr_t      base_address_i,
    input  vlsu_pkg::addr_t      stride_i,
    output vlsu_pkg::addr_t      addr_o
);

    import vlsu_pkg::*;

    addr_t offset_r;

    //////////////////////////////////////////////////////////////////////
    // Running stride offset
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_r <= '0;
        end else if (state_i == LSU_IDLE) begin
            offset_r <= '0;
        end else if (state_i == LSU_EXEC) begin
            // Negative strides wrap naturally
            offset_r <= offset_r + stride_i;
        end
    end

    assign addr_o = base_address_i + offset_r;

endmodule

//--- hw/element_counter.sv
`timescale 1ns/1ns

module element_counter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::lsu_state_e  state_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  vlsu_pkg::elem_idx_t   vl_i,
    output vlsu_pkg::elem_idx_t   elem_idx_o,
    output logic                  last_elem_o
);

    import vlsu_pkg::*;

    elem_idx_t elem_idx_r;
    elem_idx_t elem_limit;
    elem_idx_t n_active;

    // Stays at zero outside execute so a back-to-back start begins at 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            elem_idx_r <= '0;
        end else if (state_i == LSU_EXEC) begin
            elem_idx_r <= elem_idx_r + elem_idx_t'(1);
        end else begin
            elem_idx_r <= '0;
        end
    end

    // Elements that fit in one register: 8, 4 or 2
    assign elem_limit = elem_idx_t'(VLENB >> width_i);
    assign n_active   = (vl_i < elem_limit) ? vl_i : elem_limit;

    assign elem_idx_o  = elem_idx_r;
    assign last_elem_o = (elem_idx_r == n_active - elem_idx_t'(1));

endmodule

//--- hw/load_collect.sv
`timescale 1ns/1ns

module load_collect (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  logic                  is_store_i,
    input  vlsu_pkg::lsu_state_e  state_i,
    input  vlsu_pkg::elem_width_e width_i,
    input  vlsu_pkg::elem_idx_t   elem_idx_i,
    input  logic [1:0]            addr_low_i,
    input  vlsu_pkg::bus_data_t   mem_read_data_i,
    output vlsu_pkg::vreg_t       read_data_o
);

    import vlsu_pkg::*;

    logic      tag_valid_r;
    elem_idx_t tag_idx_r;
    logic [1:0] tag_low_r;
    bus_data_t aligned_data;

    //////////////////////////////////////////////////////////////////////
    // Tag stage, one per presented load element
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_valid_r <= 1'b0;
        end else begin
            tag_valid_r <= (state_i == LSU_EXEC) && !is_store_i;
        end
    end

    always_ff @(posedge clk) begin
        tag_idx_r <= elem_idx_i;
        tag_low_r <= addr_low_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Data stage
    //////////////////////////////////////////////////////////////////////

    // Bring the addressed byte down to lane 0
    assign aligned_data = mem_read_data_i >> {tag_low_r, 3'b000};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= '0;
        end else if (start_i && (state_i == LSU_IDLE)) begin
            read_data_o <= '0;
        end else if (tag_valid_r) begin
            unique case (width_i)
                EW8:  read_data_o[8*tag_idx_r[2:0] +: 8] <= aligned_data[7:0];
                EW16: read_data_o[16*tag_idx_r[1:0] +: 16] <= aligned_data[15:0];
                default: begin
                    read_data_o[32*tag_idx_r[0] +: 32] <= aligned_data;
                end
            endcase
        end
    end

endmodule

//--- hw/lsu_fsm.sv
`timescale 1ns/1ns

module lsu_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  vlsu_pkg::elem_idx_t  vl_i,
    input  logic                 last_elem_i,
    output vlsu_pkg::lsu_state_e state_o,
    output logic                 hold_o
);

    import vlsu_pkg::*;

    lsu_state_e state_r;
    lsu_state_e state_next;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_r <= LSU_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    always_comb begin
        unique case (state_r)
            LSU_IDLE: begin
                // Empty vector does nothing
                if (start_i && (vl_i != '0)) begin
                    state_next = LSU_EXEC;
                end else begin
                    state_next = LSU_IDLE;
                end
            end
            LSU_EXEC: begin
                if (last_elem_i) begin
                    state_next = LSU_DRAIN;
                end else begin
                    state_next = LSU_EXEC;
                end
            end
            // Last load beat lands here
            LSU_DRAIN: state_next = LSU_IDLE;
            default:   state_next = LSU_IDLE;
        endcase
    end

    assign state_o = state_r;
    assign hold_o  = (state_r == LSU_EXEC) || (state_r == LSU_DRAIN);

endmodule

//--- hw/store_lane_unit.sv
`timescale 1ns/1ns

module store_lane_unit (
    input  vlsu_pkg::lsu_state_e state_i,
    input  vlsu_pkg::lsu_cmd_t   cmd_i,
    input  vlsu_pkg::elem_idx_t  elem_idx_i,
    input  logic [1:0]           addr_low_i,
    input  vlsu_pkg::vreg_t      mask_i,
    input  vlsu_pkg::vreg_t      write_data_i,
    output vlsu_pkg::strb_t      wstrb_o,
    output vlsu_pkg::bus_data_t  wdata_o
);

    import vlsu_pkg::*;

    logic  elem_active;
    strb_t lane_strb;

    //////////////////////////////////////////////////////////////////////
    // Write data
    //////////////////////////////////////////////////////////////////////

    // Element copied to every lane so any byte offset finds it
    always_comb begin
        unique case (cmd_i.width)
            EW8:     wdata_o = {4{write_data_i[8*elem_idx_i[2:0] +: 8]}};
            EW16:    wdata_o = {2{write_data_i[16*elem_idx_i[1:0] +: 16]}};
            default: wdata_o = write_data_i[32*elem_idx_i[0] +: 32];
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Byte strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (cmd_i.width)
            EW8:  lane_strb = strb_t'(4'b0001) << addr_low_i;
            EW16: begin
                if (addr_low_i[1]) begin
                    lane_strb = 4'b1100;
                end else begin
                    lane_strb = 4'b0011;
                end
            end
            default: lane_strb = 4'b1111;
        endcase
    end

    // Masked-off elements leave memory untouched
    assign elem_active = (state_i == LSU_EXEC) && cmd_i.is_store
                         && (cmd_i.vm || mask_i[elem_idx_i]);

    assign wstrb_o = elem_active ? lane_strb : '0;

endmodule

//--- hw/vector_lsu.sv
`timescale 1ns/1ns

module vector_lsu (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start_i,
    input  vlsu_pkg::lsu_cmd_t  cmd_i,
    input  vlsu_pkg::addr_t     base_address_i,
    input  vlsu_pkg::addr_t     stride_i,
    input  vlsu_pkg::elem_idx_t vl_i,
    input  vlsu_pkg::vreg_t     mask_i,
    input  vlsu_pkg::vreg_t     write_data_i,
    output logic                hold_o,
    output vlsu_pkg::mem_req_t  mem_req_o,
    input  vlsu_pkg::bus_data_t mem_read_data_i,
    output vlsu_pkg::vreg_t     read_data_o
);

    import vlsu_pkg::*;

    lsu_state_e state;
    elem_idx_t  elem_idx;
    logic       last_elem;
    addr_t      addr;
    strb_t      wstrb;
    bus_data_t  wdata;
    logic       start_nonempty;

    // A zero-length start must not wipe the previous result
    assign start_nonempty = start_i && (vl_i != '0);

    lsu_fsm u_lsu_fsm (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .vl_i        (vl_i),
        .last_elem_i (last_elem),
        .state_o     (state),
        .hold_o      (hold_o)
    );

    element_counter u_element_counter (
        .clk         (clk),
        .reset_n     (reset_n),
        .state_i     (state),
        .width_i     (cmd_i.width),
        .vl_i        (vl_i),
        .elem_idx_o  (elem_idx),
        .last_elem_o (last_elem)
    );

    address_gen u_address_gen (
        .clk            (clk),
        .reset_n        (reset_n),
        .state_i        (state),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .addr_o         (addr)
    );

    store_lane_unit u_store_lane_unit (
        .state_i      (state),
        .cmd_i        (cmd_i),
        .elem_idx_i   (elem_idx),
        .addr_low_i   (addr[1:0]),
        .mask_i       (mask_i),
        .write_data_i (write_data_i),
        .wstrb_o      (wstrb),
        .wdata_o      (wdata)
    );

    load_collect u_load_collect (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_nonempty),
        .is_store_i      (cmd_i.is_store),
        .state_i         (state),
        .width_i         (cmd_i.width),
        .elem_idx_i      (elem_idx),
        .addr_low_i      (addr[1:0]),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

    assign mem_req_o = '{addr: addr, wstrb: wstrb, wdata: wdata};

endmodule

//--- hw/vlsu_pkg.sv
package vlsu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    localparam int VLEN      = 64;
    localparam int BUS_WIDTH = 32;
    localparam int STRB_W    = BUS_WIDTH / 8;
    localparam int VLENB     = VLEN / 8;
    localparam int CNT_W     = 4;

    // Vector register value, also used for the mask
    typedef logic [VLEN-1:0]      vreg_t;
    typedef logic [31:0]          addr_t;
    typedef logic [BUS_WIDTH-1:0] bus_data_t;
    typedef logic [STRB_W-1:0]    strb_t;

    // Element index and vl share one width
    typedef logic [CNT_W-1:0]     elem_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Value doubles as log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        LSU_IDLE  = 2'd0,
        LSU_EXEC  = 2'd1,
        LSU_DRAIN = 2'd2
    } lsu_state_e;

    typedef struct packed {
        logic        is_store;
        elem_width_e width;
        logic        vm;
    } lsu_cmd_t;

    // One bus beat toward memory
    typedef struct packed {
        addr_t     addr;
        strb_t     wstrb;
        bus_data_t wdata;
    } mem_req_t;

endpackage

//--- sim.f
hw/vlsu_pkg.sv
hw/lsu_fsm.sv
hw/element_counter.sv
hw/address_gen.sv
hw/store_lane_unit.sv
hw/load_collect.sv
hw/vector_lsu.sv
verification/tb_vector_lsu.sv

//--- verification/tb_vector_lsu.sv
`timescale 1ns/1ns

module tb_vector_lsu;

    import vlsu_pkg::*;

    localparam int NUM_TESTS = 9;
    localparam int TIMEOUT   = 40;

    typedef struct packed {
        logic        is_store;
        elem_width_e width;
        addr_t       base;
        addr_t       stride;
        elem_idx_t   vl;
        logic        vm;
        logic [7:0]  mask;
        logic        busy_start;
        vreg_t       exp_read;
    } test_row_t;

    logic      clk;
    logic      reset_n;
    logic      start_i;
    lsu_cmd_t  cmd_i;
    addr_t     base_address_i;
    addr_t     stride_i;
    elem_idx_t vl_i;
    vreg_t     mask_i;
    vreg_t     write_data_i;
    logic      hold_o;
    mem_req_t  mem_req_o;
    bus_data_t mem_read_data_i;
    vreg_t     read_data_o;

    logic [7:0] mem [256];
    logic [7:0] exp_mem [256];
    test_row_t  table_rows [NUM_TESTS];
    int         errors;
    int         checks;
    logic       timed_out;

    vector_lsu u_vector_lsu (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .cmd_i           (cmd_i),
        .base_address_i  (base_address_i),
        .stride_i        (stride_i),
        .vl_i            (vl_i),
        .mask_i          (mask_i),
        .write_data_i    (write_data_i),
        .hold_o          (hold_o),
        .mem_req_o       (mem_req_o),
        .mem_read_data_i (mem_read_data_i),
        .read_data_o     (read_data_o)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory model, read data one cycle after the address
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        mem_read_data_i <= {mem[{mem_req_o.addr[7:2], 2'd3}], mem[{mem_req_o.addr[7:2], 2'd2}],
                            mem[{mem_req_o.addr[7:2], 2'd1}], mem[{mem_req_o.addr[7:2], 2'd0}]};
        for (int j = 0; j < 4; j++) begin
            if (mem_req_o.wstrb[j]) begin
                mem[{mem_req_o.addr[7:2], j[1:0]}] <= mem_req_o.wdata[8*j +: 8];
            end
        end
    end

    function automatic logic [7:0] pattern_byte(input logic [7:0] a);
        return a ^ 8'h5A;
    endfunction

    function automatic int elem_bytes(input elem_width_e w);
        case (w)
            EW8:     return 1;
            EW16:    return 2;
            default: return 4;
        endcase
    endfunction

    // Elements per register shrink with the width
    function automatic int active_count(input test_row_t r);
        int limit;
        limit = 8 / elem_bytes(r.width);
        return (int'(r.vl) < limit) ? int'(r.vl) : limit;
    endfunction

    function automatic vreg_t expect_load(input test_row_t r);
        vreg_t      res;
        int         w;
        logic [7:0] a;
        res = '0;
        w = elem_bytes(r.width);
        for (int k = 0; k < active_count(r); k++) begin
            for (int i = 0; i < w; i++) begin
                a = 8'(r.base + k * r.stride + i);
                res[8*(k*w+i) +: 8] = pattern_byte(a);
            end
        end
        return res;
    endfunction

    task automatic expect_store(input test_row_t r, input vreg_t data);
        int         w;
        logic [7:0] a;
        w = elem_bytes(r.width);
        for (int k = 0; k < active_count(r); k++) begin
            if (r.vm || r.mask[k]) begin
                for (int i = 0; i < w; i++) begin
                    a = 8'(r.base + k * r.stride + i);
                    exp_mem[a] = data[8*(k*w+i) +: 8];
                end
            end
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < 256; a++) begin
            mem[a] = pattern_byte(8'(a));
            exp_mem[a] = pattern_byte(8'(a));
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic test_row_t make_row(input logic st, input elem_width_e w,
                                           input addr_t base, input addr_t stride,
                                           input elem_idx_t vl, input logic vm,
                                           input logic [7:0] mask, input logic busy);
        return '{is_store: st, width: w, base: base, stride: stride, vl: vl, vm: vm,
                 mask: mask, busy_start: busy, exp_read: '0};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////////////////////////

    task automatic build_table();
        vreg_t prev;
        table_rows[0] = make_row(0, EW32, 32'h60, 32'd8, 4'd2, 1, 8'h00, 0);
        table_rows[1] = make_row(0, EW8,  32'h13, 32'd3, 4'd8, 1, 8'h00, 0);
        table_rows[2] = make_row(0, EW16, 32'h22, 32'd6, 4'd7, 1, 8'h00, 0);
        table_rows[3] = make_row(1, EW16, 32'h40, 32'd6, 4'd4, 0, 8'hF5, 0);
        table_rows[4] = make_row(0, EW8,  32'h30, 32'd1, 4'd3, 1, 8'h00, 0);
        table_rows[5] = make_row(0, EW8,  32'h90, 32'd1, 4'd0, 1, 8'h00, 0);
        table_rows[6] = make_row(0, EW8,  32'h70, 32'd2, 4'd8, 1, 8'h00, 1);
        table_rows[7] = make_row(1, EW8,  32'h81, 32'd5, 4'd8, 1, 8'h00, 0);
        table_rows[8] = make_row(1, EW32, 32'hC0, -32'sd8, 4'd5, 1, 8'h00, 0);
        prev = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            // Ignored start keeps the previous result
            if (table_rows[t].vl == 0) begin
                table_rows[t].exp_read = prev;
            end else if (table_rows[t].is_store) begin
                table_rows[t].exp_read = '0;
            end else begin
                table_rows[t].exp_read = expect_load(table_rows[t]);
            end
            prev = table_rows[t].exp_read;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t r;
        vreg_t     data;
        int        cycles;
        int        hold_cnt;
        int        exp_hold;
        int        errors_before;
        r = table_rows[t];
        errors_before = errors;
        data = {$urandom(), $urandom()};
        fill_memory();
        if (r.is_store && r.vl != 0) begin
            expect_store(r, data);
        end
        exp_hold = (r.vl == 0) ? 0 : active_count(r) + 1;
        cmd_i = '{is_store: r.is_store, width: r.width, vm: r.vm};
        base_address_i = r.base;
        stride_i = r.stride;
        vl_i = r.vl;
        mask_i = 64'(r.mask);
        write_data_i = data;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        cycles = 0;
        hold_cnt = 0;
        while (hold_o && cycles < TIMEOUT) begin
            hold_cnt++;
            // Element k sits at base plus k times stride
            if (cycles < active_count(r)) begin
                check_value("mem_req_o.addr", 64'(mem_req_o.addr),
                            64'(addr_t'(r.base + cycles * r.stride)));
            end
            // Second strobe in the middle of a run
            start_i = r.busy_start && (cycles == 1);
            @(posedge clk);
            #1;
            cycles++;
        end
        start_i = 1'b0;
        if (hold_o) begin
            timed_out = 1'b1;
            errors++;
            $display("test %0d: hold_o did not fall within %0d cycles", t, TIMEOUT);
        end else begin
            check_value("hold_o cycles", 64'(hold_cnt), 64'(exp_hold));
            check_value("read_data_o", read_data_o, r.exp_read);
            for (int a = 0; a < 256; a++) begin
                check_value($sformatf("mem[0x%02h]", a), 64'(mem[a]), 64'(exp_mem[a]));
            end
        end
        if (errors == errors_before) begin
            $display("test %0d ok", t);
        end else begin
            $display("test %0d: %0d mismatches", t, errors - errors_before);
        end
    endtask

    initial begin
        int seed_dummy;
        clk = 1'b0;
        reset_n = 1'b0;
        start_i = 1'b0;
        // Store command during reset exposes a stray write strobe
        cmd_i = '{is_store: 1'b1, width: EW32, vm: 1'b1};
        base_address_i = '0;
        stride_i = '0;
        vl_i = '0;
        mask_i = '0;
        write_data_i = '0;
        mem_read_data_i = '0;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        seed_dummy = $urandom(62);
        build_table();
        fill_memory();
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_value("hold_o", 64'(hold_o), 64'(0));
        check_value("mem_req_o.wstrb", 64'(mem_req_o.wstrb), 64'(0));
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
